//--- dv/tb_yuv_rgb.sv
module tb_yuv_rgb;
	timeunit 1ns;
	timeprecision 100ps;
	import yuv_rgb_pkg::*;

	localparam int DRAIN_LIMIT = 30000; // Cycles per wait for a row's pixels

	logic Clock = 1'b0;
	logic resetn;
	logic in_valid;
	yuv_word_t in_word;
	logic in_credit;
	logic out_valid;
	logic [PIXEL_W-1:0] out_pixel;
	logic out_credit;

	logic [WORD_W-1:0] word_q [$];
	logic [PIXEL_W-1:0] exp_q [$];
	logic [PIXEL_W-1:0] rx_q [$];
	logic [PIXEL_W-1:0] last_px; // Final pixel of the last drained row
	logic [BYTE_W-1:0] row_ye [PAIRS_PER_ROW];
	logic [BYTE_W-1:0] row_yo [PAIRS_PER_ROW];
	logic [BYTE_W-1:0] row_u [PAIRS_PER_ROW];
	logic [BYTE_W-1:0] row_v [PAIRS_PER_ROW];
	int src_credits = 0;
	int granted = 0;
	int rx_total = 0;
	int errors = 0;
	int checks = 0;
	int cyc = 0;
	bit sink_slow = 1'b0; // Sink withholds credits in long stretches

	yuv_rgb_top dut_i (
		.Clock      (Clock),
		.resetn     (resetn),
		.in_valid   (in_valid),
		.in_word    (in_word),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_pixel  (out_pixel),
		.out_credit (out_credit)
	);

	always #20 Clock = ~Clock;

	task automatic verify(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("Error at %0t: %s", $time, msg);
		end
	endtask

	// Source sends only with a credit in hand
	always @(posedge Clock) begin
		#2;
		if (resetn && src_credits > 0 && word_q.size() > 0) begin
			in_valid = 1'b1;
			in_word = word_q.pop_front();
			src_credits--;
		end else begin
			in_valid = 1'b0;
		end
	end

	always @(posedge Clock) begin
		cyc++;
		#2;
		out_credit = 1'b0;
		if (resetn && granted - rx_total < OUT_CREDIT_MAX) begin
			if (!sink_slow || cyc % 80 >= 60) begin
				out_credit = 1'b1;
				granted++;
			end
		end
	end

	always @(negedge Clock) begin
		if (resetn && in_credit)
			src_credits++;
		if (out_valid) begin
			rx_q.push_back(out_pixel);
			rx_total++;
			verify(rx_total <= granted,
				$sformatf("%0d pixels with %0d credits granted", rx_total, granted));
		end
	end

	function automatic int clip_byte(input int v);
		if (v < 0)
			return 0;
		if (v > 255)
			return 255;
		return v;
	endfunction

	// Edge samples replicated past both ends of the row
	function automatic int chroma_at(input bit use_v, input int i);
		int k;
		k = (i < 0) ? 0 : (i > PAIRS_PER_ROW - 1) ? PAIRS_PER_ROW - 1 : i;
		return use_v ? int'(row_v[k]) : int'(row_u[k]);
	endfunction

	function automatic int odd_chroma(input bit use_v, input int j);
		int acc;
		acc = TAP_FAR * (chroma_at(use_v, j - 2) + chroma_at(use_v, j + 3))
			+ TAP_MID * (chroma_at(use_v, j - 1) + chroma_at(use_v, j + 2))
			+ TAP_NEAR * (chroma_at(use_v, j) + chroma_at(use_v, j + 1));
		return clip_byte((acc + 128) >>> 8);
	endfunction

	function automatic logic [PIXEL_W-1:0] rgb_model(input int y, input int u, input int v);
		int yt;
		int r;
		int g;
		int b;
		yt = COEF_Y * (y - Y_OFFSET);
		r = yt + COEF_RV * (v - C_OFFSET);
		g = yt + COEF_GU * (u - C_OFFSET) + COEF_GV * (v - C_OFFSET);
		b = yt + COEF_BU * (u - C_OFFSET);
		return {8'(clip_byte(r >>> FRAC_W)), 8'(clip_byte(g >>> FRAC_W)),
			8'(clip_byte(b >>> FRAC_W))};
	endfunction

	task automatic fill_const(input int y, input int u, input int v);
		for (int j = 0; j < PAIRS_PER_ROW; j++) begin
			row_ye[j] = 8'(y);
			row_yo[j] = 8'(y);
			row_u[j] = 8'(u);
			row_v[j] = 8'(v);
		end
	endtask

	task automatic fill_random();
		for (int j = 0; j < PAIRS_PER_ROW; j++) begin
			row_ye[j] = 8'($urandom);
			row_yo[j] = 8'($urandom);
			row_u[j] = 8'($urandom);
			row_v[j] = 8'($urandom);
		end
	endtask

	// Luma word then chroma word per pair, even pixel expected first
	task automatic send_row();
		for (int j = 0; j < PAIRS_PER_ROW; j++) begin
			word_q.push_back({row_ye[j], row_yo[j]});
			word_q.push_back({row_u[j], row_v[j]});
			exp_q.push_back(rgb_model(row_ye[j], row_u[j], row_v[j]));
			exp_q.push_back(rgb_model(row_yo[j], odd_chroma(1'b0, j), odd_chroma(1'b1, j)));
		end
	endtask

	task automatic drain(input string name);
		int waited;
		int idx;
		logic [PIXEL_W-1:0] got;
		logic [PIXEL_W-1:0] want;
		waited = 0;
		idx = 0;
		while (rx_q.size() < exp_q.size() && waited < DRAIN_LIMIT) begin
			@(posedge Clock);
			waited++;
		end
		if (rx_q.size() < exp_q.size()) begin
			$display("Timeout in %s test, only %0d of %0d pixels arrived",
				name, rx_q.size(), exp_q.size());
			errors++;
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Checks failed");
			$finish;
		end else begin
			while (exp_q.size() > 0) begin
				got = rx_q.pop_front();
				want = exp_q.pop_front();
				verify(got === want, $sformatf("%s pixel %0d got %06h expected %06h",
					name, idx, got, want));
				last_px = got;
				idx++;
			end
		end
	endtask

	task automatic test_reset();
		repeat (20) @(posedge Clock);
		verify(src_credits == IN_DEPTH,
			$sformatf("%0d input credits after reset, expected %0d", src_credits, IN_DEPTH));
		verify(rx_total == 0, "out_valid rose with no input sent");
	endtask

	task automatic test_flat();
		fill_const(128, 128, 128);
		send_row();
		drain("flat");
		// Odd pixel keeps the constant chroma
		verify(last_px === rgb_model(128, 128, 128),
			$sformatf("flat row odd pixel %06h changed by interpolation", last_px));
	endtask

	task automatic test_random_row();
		fill_random();
		send_row();
		drain("random");
	endtask

	task automatic test_clipping();
		fill_const(255, 128, 255);
		send_row();
		drain("clip high");
		verify(last_px[23:16] === 8'd255, "red not saturated on a bright row");
		fill_const(0, 0, 128);
		send_row();
		drain("clip low");
		verify(last_px[7:0] === 8'd0, "blue not clipped to zero on a dark row");
	endtask

	task automatic test_backpressure();
		sink_slow = 1'b1;
		fill_random();
		send_row();
		drain("backpressure");
		sink_slow = 1'b0;
	endtask

	task automatic test_two_rows();
		fill_random();
		send_row();
		fill_random();
		send_row();
		drain("two rows");
	endtask

	initial begin
		resetn = 1'b0;
		in_valid = 1'b0;
		in_word = '0;
		out_credit = 1'b0;
		void'($urandom(32'h1f340dd1));
		repeat (4) @(posedge Clock);
		#2;
		resetn = 1'b1;
		test_reset();
		test_flat();
		test_random_row();
		test_clipping();
		test_backpressure();
		test_two_rows();
		errors += dut_i.sva_i.failures;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- dv/yuv_rgb_sva.sv
module yuv_rgb_sva (
	input logic                            Clock,
	input logic                            resetn,
	input logic                            out_valid,
	input logic [yuv_rgb_pkg::PIXEL_W-1:0] out_pixel
);
	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0; // Assertion failures so far

	quiet_in_reset: assert property (@(posedge Clock) !resetn |-> !out_valid)
		else begin
			failures++;
			$error("out_valid high while resetn is low");
		end

	pixel_known: assert property (@(posedge Clock) disable iff (!resetn)
		out_valid |-> !$isunknown(out_pixel))
		else begin
			failures++;
			$error("out_pixel unknown while out_valid is high");
		end

	// A pair is two beats, then the bus idles
	two_beat_max: assert property (@(posedge Clock) disable iff (!resetn)
		out_valid ##1 out_valid |=> !out_valid)
		else begin
			failures++;
			$error("out_valid high for more than two cycles");
		end

endmodule

bind yuv_rgb_top yuv_rgb_sva sva_i (
	.Clock     (Clock),
	.resetn    (resetn),
	.out_valid (out_valid),
	.out_pixel (out_pixel)
);

//--- src.f
verilog/yuv_rgb_pkg.sv
verilog/input_fifo.sv
verilog/conv_ctrl.sv
verilog/pair_window.sv
verilog/chroma_fir.sv
verilog/color_matrix.sv
verilog/yuv_rgb_top.sv
dv/yuv_rgb_sva.sv
dv/tb_yuv_rgb.sv

//--- verilog/chroma_fir.sv
module chroma_fir (
	input  logic                                Clock,
	input  logic                                resetn,
	input  logic [5:0][yuv_rgb_pkg::BYTE_W-1:0] u_taps,
	input  logic [5:0][yuv_rgb_pkg::BYTE_W-1:0] v_taps,
	input  logic [yuv_rgb_pkg::WORD_W-1:0]      y_pair,
	input  logic                                pair_step,
	output logic [yuv_rgb_pkg::BYTE_W-1:0]      u_even,
	output logic [yuv_rgb_pkg::BYTE_W-1:0]      v_even,
	output logic [yuv_rgb_pkg::BYTE_W-1:0]      u_odd,
	output logic [yuv_rgb_pkg::BYTE_W-1:0]      v_odd,
	output logic [yuv_rgb_pkg::BYTE_W-1:0]      y_even,
	output logic [yuv_rgb_pkg::BYTE_W-1:0]      y_odd,
	output logic                                pair_valid
);
	import yuv_rgb_pkg::*;

	// Odd sample sits between slots 3 and 2
	function automatic logic [BYTE_W-1:0] interp(input logic [5:0][BYTE_W-1:0] t);
		int acc;
		acc = TAP_FAR * (int'(t[5]) + int'(t[0]))
			+ TAP_MID * (int'(t[4]) + int'(t[1]))
			+ TAP_NEAR * (int'(t[3]) + int'(t[2]));
		acc = (acc + 128) >>> 8; // Weights sum to 256
		if (acc < 0)
			return '0;
		if (acc > 255)
			return '1;
		return acc[BYTE_W-1:0];
	endfunction

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn)
			pair_valid <= 1'b0;
		else
			pair_valid <= pair_step;
	end

	// Held until the next pair, color_matrix reads them for two cycles
	always_ff @(posedge Clock) begin
		if (pair_step) begin
			u_odd <= interp(u_taps);
			v_odd <= interp(v_taps);
			u_even <= u_taps[3];
			v_even <= v_taps[3];
			y_even <= y_pair[WORD_W-1:BYTE_W];
			y_odd <= y_pair[BYTE_W-1:0];
		end
	end

endmodule

//--- verilog/color_matrix.sv
module color_matrix (
	input  logic                             Clock,
	input  logic                             resetn,
	input  logic [yuv_rgb_pkg::BYTE_W-1:0]   u_even,
	input  logic [yuv_rgb_pkg::BYTE_W-1:0]   v_even,
	input  logic [yuv_rgb_pkg::BYTE_W-1:0]   u_odd,
	input  logic [yuv_rgb_pkg::BYTE_W-1:0]   v_odd,
	input  logic [yuv_rgb_pkg::BYTE_W-1:0]   y_even,
	input  logic [yuv_rgb_pkg::BYTE_W-1:0]   y_odd,
	input  logic                             pair_valid,
	output logic                             out_valid,
	output logic [yuv_rgb_pkg::PIXEL_W-1:0]  out_pixel
);
	import yuv_rgb_pkg::*;

	logic odd_phase; // Second beat of the pair
	logic [BYTE_W-1:0] sel_y, sel_u, sel_v;
	logic signed [31:0] y_term, u_term, v_term;
	logic signed [31:0] r_sum, g_sum, b_sum;

	// Negative to 0, anything past the integer byte to 255
	function automatic logic [BYTE_W-1:0] clip(input logic signed [31:0] s);
		if (s < 0)
			return '0;
		if (|s[30:FRAC_W+BYTE_W])
			return '1;
		return s[FRAC_W +: BYTE_W];
	endfunction

	always_comb begin
		sel_y = pair_valid ? y_even : y_odd;
		sel_u = pair_valid ? u_even : u_odd;
		sel_v = pair_valid ? v_even : v_odd;

		y_term = COEF_Y * (int'(sel_y) - Y_OFFSET);
		u_term = int'(sel_u) - C_OFFSET;
		v_term = int'(sel_v) - C_OFFSET;

		r_sum = y_term + COEF_RV * v_term;
		g_sum = y_term + COEF_GU * u_term + COEF_GV * v_term;
		b_sum = y_term + COEF_BU * u_term;
	end

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			odd_phase <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			odd_phase <= pair_valid;
			out_valid <= pair_valid | odd_phase;
		end
	end

	always_ff @(posedge Clock) begin
		if (pair_valid || odd_phase)
			out_pixel <= {clip(r_sum), clip(g_sum), clip(b_sum)}; // R in the top byte
	end

endmodule

//--- verilog/conv_ctrl.sv
module conv_ctrl (
	input  logic Clock,
	input  logic resetn,
	input  logic fifo_valid,
	output logic fifo_pop,
	input  logic out_credit,
	output logic luma_load,
	output logic chroma_step,
	output logic row_first,
	output logic flush,
	output logic pair_step
);
	import yuv_rgb_pkg::*;

	logic expect_chroma; // Next word is the chroma half of the pair
	logic [PAIR_IDX_W-1:0] pair_idx;
	logic [1:0] steps_done; // Chroma steps in this row, saturates at 3
	logic [1:0] flush_left;
	logic [1:0] cool; // Keeps pair steps three cycles apart
	logic [OUT_CREDIT_W-1:0] credits;

	logic in_flush;
	logic can_pair;
	logic chroma_pop;
	logic last_pair;
	logic take;

	assign in_flush = (flush_left != 2'd0);

	// Two output beats per pair, and the output bus must have idled
	assign can_pair = (credits >= OUT_CREDIT_W'(2)) && (cool == 2'd0);
	assign last_pair = (pair_idx == PAIR_IDX_W'(PAIRS_PER_ROW - 1));

	always_comb begin
		fifo_pop = 1'b0;
		if (!in_flush && fifo_valid) begin
			if (!expect_chroma)
				fifo_pop = 1'b1;
			else if (steps_done != 2'd3 || can_pair)
				fifo_pop = 1'b1; // Early steps only prime the window
		end
	end

	assign luma_load = fifo_pop & ~expect_chroma;
	assign chroma_pop = fifo_pop & expect_chroma;
	assign flush = in_flush & can_pair;
	assign chroma_step = chroma_pop | flush;
	assign row_first = chroma_pop & (pair_idx == '0);

	// Fourth chroma step onward centres a pair, every flush does too
	assign take = (chroma_pop && steps_done == 2'd3) || flush;

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			expect_chroma <= 1'b0;
			pair_idx <= '0;
			steps_done <= 2'd0;
			flush_left <= 2'd0;
			cool <= 2'd0;
			credits <= '0;
			pair_step <= 1'b0;
		end else begin
			pair_step <= take;

			if (fifo_pop)
				expect_chroma <= ~expect_chroma;

			if (chroma_pop) begin
				if (last_pair) begin
					pair_idx <= '0;
					steps_done <= 2'd0;
					flush_left <= 2'd3; // Lead-out for the last three pairs
				end else begin
					pair_idx <= pair_idx + 1'b1;
					if (steps_done != 2'd3)
						steps_done <= steps_done + 1'b1;
				end
			end

			if (flush)
				flush_left <= flush_left - 1'b1;

			if (take)
				cool <= 2'd2;
			else if (cool != 2'd0)
				cool <= cool - 1'b1;

			credits <= credits + OUT_CREDIT_W'(out_credit)
				- (take ? OUT_CREDIT_W'(2) : OUT_CREDIT_W'(0));
		end
	end

endmodule

//--- verilog/input_fifo.sv
module input_fifo (
	input  logic                   Clock,
	input  logic                   resetn,
	input  logic                   in_valid,
	input  yuv_rgb_pkg::yuv_word_t in_word,
	output logic                   in_credit,
	input  logic                   fifo_pop,
	output logic                   fifo_valid,
	output yuv_rgb_pkg::yuv_word_t fifo_word
);
	import yuv_rgb_pkg::*;

	yuv_word_t mem [IN_DEPTH];
	logic [IN_PTR_W-1:0] wr_ptr, rd_ptr;
	logic [IN_CNT_W-1:0] count;
	logic [IN_CNT_W-1:0] grant_left; // Initial credits still owed
	logic grant_started;

	assign fifo_valid = (count != '0);
	assign fifo_word = mem[rd_ptr];

	// A pop during the grant window only postpones the next grant
	assign in_credit = fifo_pop | (grant_started & (grant_left != '0));

	always_ff @(posedge Clock) begin
		if (in_valid)
			mem[wr_ptr] <= in_word; // Space guaranteed by the credits
	end

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			grant_left <= IN_CNT_W'(IN_DEPTH);
			grant_started <= 1'b0;
		end else begin
			grant_started <= 1'b1;
			if (grant_started && grant_left != '0 && !fifo_pop)
				grant_left <= grant_left - 1'b1;

			if (in_valid)
				wr_ptr <= (wr_ptr == IN_PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (fifo_pop)
				rd_ptr <= (rd_ptr == IN_PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			case ({in_valid, fifo_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- verilog/pair_window.sv
module pair_window (
	input  logic                                  Clock,
	input  logic                                  resetn,
	input  yuv_rgb_pkg::yuv_word_t                fifo_word,
	input  logic                                  luma_load,
	input  logic                                  chroma_step,
	input  logic                                  row_first,
	input  logic                                  flush,
	output logic [5:0][yuv_rgb_pkg::BYTE_W-1:0]   u_taps,
	output logic [5:0][yuv_rgb_pkg::BYTE_W-1:0]   v_taps,
	output logic [yuv_rgb_pkg::WORD_W-1:0]        y_pair
);
	import yuv_rgb_pkg::*;

	// Slot 5 oldest, slot 0 newest, slot 3 is the centred pair
	logic [5:0][BYTE_W-1:0] u_win, v_win;
	logic [3:0][WORD_W-1:0] y_dly;
	logic [WORD_W-1:0] luma_hold;

	// Row start fills the window, lead-out repeats the last sample
	function automatic logic [5:0][BYTE_W-1:0] next_window(
		input logic [5:0][BYTE_W-1:0] win,
		input logic [BYTE_W-1:0] sample,
		input logic fill,
		input logic rep
	);
		logic [BYTE_W-1:0] newest;
		newest = rep ? win[0] : sample;
		if (fill)
			return {6{sample}};
		return {win[4:0], newest};
	endfunction

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			u_win <= '0;
			v_win <= '0;
			y_dly <= '0;
			luma_hold <= '0;
		end else begin
			if (luma_load)
				luma_hold <= {fifo_word.luma.y_even, fifo_word.luma.y_odd};
			if (chroma_step) begin
				u_win <= next_window(u_win, fifo_word.chroma.u, row_first, flush);
				v_win <= next_window(v_win, fifo_word.chroma.v, row_first, flush);
				y_dly <= {y_dly[2:0], luma_hold}; // Stale luma shifted in on flush
			end
		end
	end

	assign u_taps = u_win;
	assign v_taps = v_win;
	assign y_pair = y_dly[3]; // Three steps behind, matches slot 3

endmodule

//--- verilog/yuv_rgb_pkg.sv
package yuv_rgb_pkg;

	// Sample and bus widths
	localparam int BYTE_W = 8;
	localparam int WORD_W = 16;
	localparam int PIXEL_W = 24;

	// Row geometry, at least 4 pairs
	localparam int PAIRS_PER_ROW = 160;
	localparam int PAIR_IDX_W = $clog2(PAIRS_PER_ROW);

	// Input buffer depth doubles as the initial credit grant
	localparam int IN_DEPTH = 4;
	localparam int IN_PTR_W = $clog2(IN_DEPTH);
	localparam int IN_CNT_W = $clog2(IN_DEPTH + 1);

	// Sink never holds more unused credits than this
	localparam int OUT_CREDIT_MAX = 8;
	localparam int OUT_CREDIT_W = $clog2(OUT_CREDIT_MAX + 1);

	// Colour matrix, 16-bit fraction
	localparam int FRAC_W = 16;
	localparam int COEF_Y = 76284;
	localparam int COEF_RV = 104595;
	localparam int COEF_GU = -25624;
	localparam int COEF_GV = -53281;
	localparam int COEF_BU = 132251;

	// Six-tap chroma interpolation weights
	localparam int TAP_NEAR = 159;
	localparam int TAP_MID = -52;
	localparam int TAP_FAR = 21;

	localparam int Y_OFFSET = 16;
	localparam int C_OFFSET = 128;

	// Stream word, luma pair or chroma pair depending on position
	typedef union packed {
		struct packed {
			logic [BYTE_W-1:0] y_even;
			logic [BYTE_W-1:0] y_odd;
		} luma;
		struct packed {
			logic [BYTE_W-1:0] u;
			logic [BYTE_W-1:0] v;
		} chroma;
	} yuv_word_t;

endpackage

//--- verilog/yuv_rgb_top.sv
module yuv_rgb_top (
	input  logic                            Clock,
	input  logic                            resetn,
	input  logic                            in_valid,
	input  yuv_rgb_pkg::yuv_word_t          in_word,
	output logic                            in_credit,
	output logic                            out_valid,
	output logic [yuv_rgb_pkg::PIXEL_W-1:0] out_pixel,
	input  logic                            out_credit
);
	import yuv_rgb_pkg::*;

	yuv_word_t fifo_word;
	logic fifo_valid;
	logic fifo_pop;

	logic luma_load, chroma_step, row_first, flush, pair_step;

	logic [5:0][BYTE_W-1:0] u_taps, v_taps;
	logic [WORD_W-1:0] y_pair;

	logic [BYTE_W-1:0] u_even, v_even, u_odd, v_odd, y_even, y_odd;
	logic pair_valid;

	input_fifo u_input_fifo (
		.Clock      (Clock),
		.resetn     (resetn),
		.in_valid   (in_valid),
		.in_word    (in_word),
		.in_credit  (in_credit),
		.fifo_pop   (fifo_pop),
		.fifo_valid (fifo_valid),
		.fifo_word  (fifo_word)
	);

	conv_ctrl u_conv_ctrl (
		.Clock       (Clock),
		.resetn      (resetn),
		.fifo_valid  (fifo_valid),
		.fifo_pop    (fifo_pop),
		.out_credit  (out_credit),
		.luma_load   (luma_load),
		.chroma_step (chroma_step),
		.row_first   (row_first),
		.flush       (flush),
		.pair_step   (pair_step)
	);

	pair_window u_pair_window (
		.Clock       (Clock),
		.resetn      (resetn),
		.fifo_word   (fifo_word),
		.luma_load   (luma_load),
		.chroma_step (chroma_step),
		.row_first   (row_first),
		.flush       (flush),
		.u_taps      (u_taps),
		.v_taps      (v_taps),
		.y_pair      (y_pair)
	);

	chroma_fir u_chroma_fir (
		.Clock      (Clock),
		.resetn     (resetn),
		.u_taps     (u_taps),
		.v_taps     (v_taps),
		.y_pair     (y_pair),
		.pair_step  (pair_step),
		.u_even     (u_even),
		.v_even     (v_even),
		.u_odd      (u_odd),
		.v_odd      (v_odd),
		.y_even     (y_even),
		.y_odd      (y_odd),
		.pair_valid (pair_valid)
	);

	color_matrix u_color_matrix (
		.Clock      (Clock),
		.resetn     (resetn),
		.u_even     (u_even),
		.v_even     (v_even),
		.u_odd      (u_odd),
		.v_odd      (v_odd),
		.y_even     (y_even),
		.y_odd      (y_odd),
		.pair_valid (pair_valid),
		.out_valid  (out_valid),
		.out_pixel  (out_pixel)
	);

endmodule
